//--- hw/cache_pkg.sv
package cache_pkg;

    // Geometry
    localparam int WAYS           = 2;
    localparam int SETS           = 8;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_BYTES     = 4;

    // Address split: tag | index | word offset | byte offset
    localparam int BYTE_BITS   = $clog2(WORD_BYTES);
    localparam int OFFSET_BITS = $clog2(WORDS_PER_LINE);
    localparam int INDEX_BITS  = $clog2(SETS);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    typedef logic [31:0]                addr_t;
    typedef logic [31:0]                word_t;
    typedef logic [WORD_BYTES-1:0]      byte_en_t;
    typedef logic [TAG_BITS-1:0]        tag_t;
    typedef logic [INDEX_BITS-1:0]      index_t;
    typedef logic [OFFSET_BITS-1:0]     offset_t;
    typedef logic [$clog2(WAYS)-1:0]    way_t;
    typedef logic [WAYS-1:0]            hit_vec_t;
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        IDLE,
        EVICT,
        FILL,
        INSTALL
    } ctrl_state_t;

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[31 -: TAG_BITS];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[BYTE_BITS + OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic offset_t addr_offset(input addr_t addr);
        return addr[BYTE_BITS +: OFFSET_BITS];
    endfunction

    // Line-aligned byte address from tag and set
    function automatic addr_t line_addr(input tag_t tag, input index_t index);
        return {tag, index, {(OFFSET_BITS + BYTE_BITS){1'b0}}};
    endfunction

endpackage

//--- hw/bus_pkg.sv
package bus_pkg;

    // CPU data bus, request held steady while stalled
    typedef struct packed {
        logic                read;
        logic                write;
        cache_pkg::addr_t    addr;
        cache_pkg::word_t    wdata;
        cache_pkg::byte_en_t byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic             stall;
        cache_pkg::word_t rdata;
    } cpu_resp_t;

    // Memory read channel
    typedef struct packed {
        logic             arvalid;
        cache_pkg::addr_t araddr;
        logic             rready;
    } rd_req_t;

    typedef struct packed {
        logic             arready;
        logic             rvalid;
        cache_pkg::word_t rdata;
        logic             rlast;
    } rd_resp_t;

    // Memory write channel, response code not carried
    typedef struct packed {
        logic             awvalid;
        cache_pkg::addr_t awaddr;
        logic             wvalid;
        cache_pkg::word_t wdata;
        logic             wlast;
        logic             bready;
    } wr_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } wr_resp_t;

endpackage

//--- hw/line_fill.sv
`timescale 1ns/1ns

module line_fill (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  cache_pkg::addr_t  addr,
    output bus_pkg::rd_req_t  rd_req,
    input  bus_pkg::rd_resp_t rd_resp,
    output logic              done,
    output cache_pkg::line_t  line
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_ADDR,
        F_DATA,
        F_DONE
    } fill_state_t;

    fill_state_t        state;
    cache_pkg::addr_t   addr_q;
    cache_pkg::offset_t beat;

    assign rd_req.arvalid = state == F_ADDR;
    assign rd_req.araddr  = addr_q;
    assign rd_req.rready  = state == F_DATA;
    assign done           = state == F_DONE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= F_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                F_IDLE: begin
                    if (start) begin
                        state <= F_ADDR;
                    end
                end
                F_ADDR: begin
                    if (rd_resp.arready) begin
                        state <= F_DATA;
                        beat  <= '0;
                    end
                end
                F_DATA: begin
                    if (rd_resp.rvalid) begin
                        beat <= beat + 1'b1;
                        if (rd_resp.rlast) begin
                            state <= F_DONE;
                        end
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // Beats arrive in word order
    always_ff @(posedge clk) begin
        if (start && state == F_IDLE) begin
            addr_q <= addr;
        end
        if (state == F_DATA && rd_resp.rvalid) begin
            line[beat] <= rd_resp.rdata;
        end
    end

endmodule

//--- hw/line_evict.sv
`timescale 1ns/1ns

module line_evict (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  cache_pkg::addr_t  addr,
    input  cache_pkg::line_t  line,
    output bus_pkg::wr_req_t  wr_req,
    input  bus_pkg::wr_resp_t wr_resp,
    output logic              done
);

    typedef enum logic [2:0] {
        E_IDLE,
        E_ADDR,
        E_DATA,
        E_RESP,
        E_DONE
    } evict_state_t;

    evict_state_t       state;
    cache_pkg::addr_t   addr_q;
    cache_pkg::line_t   line_q;
    cache_pkg::offset_t beat;

    assign wr_req.awvalid = state == E_ADDR;
    assign wr_req.awaddr  = addr_q;
    assign wr_req.wvalid  = state == E_DATA;
    assign wr_req.wdata   = line_q[beat];
    assign wr_req.wlast   = beat == cache_pkg::offset_t'(cache_pkg::WORDS_PER_LINE - 1);
    // Response code is not checked, so always ready for it
    assign wr_req.bready  = 1'b1;
    assign done           = state == E_DONE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= E_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                E_IDLE: begin
                    if (start) begin
                        state <= E_ADDR;
                    end
                end
                E_ADDR: begin
                    if (wr_resp.awready) begin
                        state <= E_DATA;
                        beat  <= '0;
                    end
                end
                E_DATA: begin
                    if (wr_resp.wready) begin
                        beat <= beat + 1'b1;
                        if (wr_req.wlast) begin
                            state <= E_RESP;
                        end
                    end
                end
                E_RESP: begin
                    if (wr_resp.bvalid) begin
                        state <= E_DONE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == E_IDLE) begin
            addr_q <= addr;
            line_q <= line;
        end
    end

endmodule

//--- hw/dcache_ways.sv
`timescale 1ns/1ns

module dcache_ways (
    input  logic                  clk,
    input  logic                  rst,
    input  bus_pkg::cpu_req_t     cpu_req,
    input  logic                  accept,
    input  cache_pkg::way_t       victim_way,
    input  logic                  install,
    input  cache_pkg::tag_entry_t install_entry,
    input  cache_pkg::line_t      fill_line,
    output cache_pkg::hit_vec_t   hit,
    output cache_pkg::word_t      rdata,
    output cache_pkg::tag_entry_t victim,
    output cache_pkg::line_t      victim_line,
    output logic                  sweep_done
);

    cache_pkg::tag_entry_t tags  [cache_pkg::WAYS][cache_pkg::SETS];
    cache_pkg::line_t      lines [cache_pkg::WAYS][cache_pkg::SETS];

    cache_pkg::index_t  index;
    cache_pkg::offset_t offset;
    cache_pkg::index_t  sweep_index;
    cache_pkg::way_t    hit_way;
    cache_pkg::word_t   hit_word;
    cache_pkg::word_t   merged_word;

    assign index  = cache_pkg::addr_index(cpu_req.addr);
    assign offset = cache_pkg::addr_offset(cpu_req.addr);

    // Tag compare across all ways of the requested set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
            hit[w] = tags[w][index].valid
                && tags[w][index].tag == cache_pkg::addr_tag(cpu_req.addr);
            if (hit[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign hit_word    = lines[hit_way][index][offset];
    assign victim      = tags[victim_way][index];
    assign victim_line = lines[victim_way][index];

    always_comb begin
        merged_word = hit_word;
        for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
            if (cpu_req.byte_en[b]) begin
                merged_word[b*8 +: 8] = cpu_req.wdata[b*8 +: 8];
            end
        end
    end

    // One set per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_index <= '0;
            sweep_done  <= 1'b0;
        end else if (!sweep_done) begin
            sweep_index <= sweep_index + 1'b1;
            if (sweep_index == cache_pkg::index_t'(cache_pkg::SETS - 1)) begin
                sweep_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!sweep_done) begin
            for (int w = 0; w < cache_pkg::WAYS; w++) begin
                tags[w][sweep_index] <= '0;
            end
        end else if (install) begin
            tags[victim_way][index]  <= install_entry;
            lines[victim_way][index] <= fill_line;
        end else if (accept && cpu_req.write) begin
            tags[hit_way][index].dirty    <= 1'b1;
            lines[hit_way][index][offset] <= merged_word;
        end
        if (accept && cpu_req.read) begin
            rdata <= hit_word;
        end
    end

endmodule

//--- hw/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  bus_pkg::cpu_req_t     cpu_req,
    input  cache_pkg::hit_vec_t   hit,
    input  logic                  sweep_done,
    input  cache_pkg::tag_entry_t victim,
    input  cache_pkg::line_t      victim_line,
    input  logic                  fill_done,
    input  cache_pkg::line_t      fill_line,
    input  logic                  evict_done,
    output logic                  stall,
    output logic                  accept,
    output cache_pkg::way_t       victim_way,
    output logic                  install,
    output cache_pkg::tag_entry_t install_entry,
    output logic                  fill_start,
    output cache_pkg::addr_t      fill_addr,
    output logic                  evict_start,
    output cache_pkg::addr_t      evict_addr,
    output cache_pkg::line_t      evict_line
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t state_next;
    cache_pkg::line_t       line_buf;
    logic [7:0]             lfsr;
    logic                   request;
    logic                   miss;
    logic                   victim_dirty;

    assign request      = cpu_req.read || cpu_req.write;
    assign miss         = sweep_done && state == cache_pkg::IDLE && request && !(|hit);
    assign victim_dirty = victim.valid && victim.dirty;

    // Hold the CPU through the sweep, any miss handling, and a fresh miss
    assign stall  = !sweep_done || state != cache_pkg::IDLE || (request && !(|hit));
    assign accept = request && !stall;

    assign victim_way = cache_pkg::way_t'(lfsr);

    assign fill_start = (miss && !victim_dirty) || (state == cache_pkg::EVICT && evict_done);
    assign fill_addr  = cache_pkg::line_addr(cache_pkg::addr_tag(cpu_req.addr),
                                             cache_pkg::addr_index(cpu_req.addr));
    assign evict_addr = cache_pkg::line_addr(victim.tag, cache_pkg::addr_index(cpu_req.addr));
    assign evict_line = line_buf;

    assign install             = state == cache_pkg::INSTALL;
    assign install_entry.valid = 1'b1;
    assign install_entry.dirty = 1'b0;
    assign install_entry.tag   = cache_pkg::addr_tag(cpu_req.addr);

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::IDLE: begin
                if (miss) begin
                    state_next = victim_dirty ? cache_pkg::EVICT : cache_pkg::FILL;
                end
            end
            cache_pkg::EVICT: begin
                if (evict_done) begin
                    state_next = cache_pkg::FILL;
                end
            end
            cache_pkg::FILL: begin
                if (fill_done) begin
                    state_next = cache_pkg::INSTALL;
                end
            end
            default: state_next = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= cache_pkg::IDLE;
            lfsr        <= 8'h5a;
            evict_start <= 1'b0;
        end else begin
            state <= state_next;
            // Eviction starts once the victim sits in the line buffer
            evict_start <= miss && victim_dirty;
            // One step per miss, taken at install so the victim stays put
            if (state == cache_pkg::INSTALL) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end
        end
    end

    // Line in flight: victim while evicting, refill data before install
    always_ff @(posedge clk) begin
        if (miss) begin
            line_buf <= victim_line;
        end else if (fill_done) begin
            line_buf <= fill_line;
        end
    end

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
    input  logic               clk,
    input  logic               rst,
    input  bus_pkg::cpu_req_t  cpu_req,
    output bus_pkg::cpu_resp_t cpu_resp,
    output bus_pkg::rd_req_t   rd_req,
    input  bus_pkg::rd_resp_t  rd_resp,
    output bus_pkg::wr_req_t   wr_req,
    input  bus_pkg::wr_resp_t  wr_resp
);

    cache_pkg::hit_vec_t   hit;
    cache_pkg::word_t      rdata;
    cache_pkg::tag_entry_t victim;
    cache_pkg::line_t      victim_line;
    cache_pkg::way_t       victim_way;
    cache_pkg::tag_entry_t install_entry;
    cache_pkg::line_t      fill_line;
    cache_pkg::line_t      evict_line;
    cache_pkg::addr_t      fill_addr;
    cache_pkg::addr_t      evict_addr;
    logic                  sweep_done;
    logic                  stall;
    logic                  accept;
    logic                  install;
    logic                  fill_start;
    logic                  fill_done;
    logic                  evict_start;
    logic                  evict_done;

    assign cpu_resp.stall = stall;
    assign cpu_resp.rdata = rdata;

    dcache_ctrl i_ctrl (
        .clk, .rst, .cpu_req, .hit, .sweep_done, .victim, .victim_line,
        .fill_done, .fill_line, .evict_done, .stall, .accept, .victim_way,
        .install, .install_entry, .fill_start, .fill_addr, .evict_start,
        .evict_addr, .evict_line
    );

    dcache_ways i_ways (
        .clk, .rst, .cpu_req, .accept, .victim_way, .install, .install_entry,
        .fill_line, .hit, .rdata, .victim, .victim_line, .sweep_done
    );

    line_fill i_fill (
        .clk, .rst, .start(fill_start), .addr(fill_addr), .rd_req, .rd_resp,
        .done(fill_done), .line(fill_line)
    );

    line_evict i_evict (
        .clk, .rst, .start(evict_start), .addr(evict_addr), .line(evict_line),
        .wr_req, .wr_resp, .done(evict_done)
    );

endmodule

//--- verification/dcache_asserts.sv
`timescale 1ns/1ns

module dcache_asserts (
    input logic               clk,
    input logic               rst,
    input bus_pkg::cpu_resp_t cpu_resp,
    input bus_pkg::rd_req_t   rd_req,
    input bus_pkg::rd_resp_t  rd_resp,
    input bus_pkg::wr_req_t   wr_req,
    input bus_pkg::wr_resp_t  wr_resp
);

    // Read address held steady until accepted
    assert property (@(posedge clk) disable iff (rst)
        rd_req.arvalid && !rd_resp.arready |=> rd_req.arvalid && $stable(rd_req.araddr))
        else $error("arvalid dropped or araddr changed before arready");

    assert property (@(posedge clk) disable iff (rst)
        wr_req.awvalid && !wr_resp.awready |=> wr_req.awvalid)
        else $error("awvalid dropped before awready");

    // Eviction always finishes before the refill
    assert property (@(posedge clk) disable iff (rst)
        !((rd_req.arvalid || rd_req.rready) && (wr_req.awvalid || wr_req.wvalid)))
        else $error("read and write channels active together");

    assert property (@(posedge clk) $fell(rst) |-> cpu_resp.stall)
        else $error("stall low in the first cycle after reset");

endmodule

bind dcache_top dcache_asserts i_asserts (
    .clk, .rst, .cpu_resp, .rd_req, .rd_resp, .wr_req, .wr_resp
);

//--- verification/tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache;

    localparam int CLK_NS       = 4;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_REQUESTS = 210;
    localparam int MISS_BUDGET  = 64;
    localparam int WATCHDOG_NS  =
        (NUM_REQUESTS * MISS_BUDGET + RESET_CYCLES + cache_pkg::SETS) * CLK_NS;

    logic               clk;
    logic               rst;
    bus_pkg::cpu_req_t  cpu_req;
    bus_pkg::cpu_resp_t cpu_resp;
    bus_pkg::rd_req_t   rd_req;
    bus_pkg::rd_resp_t  rd_resp;
    bus_pkg::wr_req_t   wr_req;
    bus_pkg::wr_resp_t  wr_resp;

    // Backing store and CPU-visible expected values, by word address
    cache_pkg::word_t mem [cache_pkg::addr_t];
    cache_pkg::word_t shadow [cache_pkg::addr_t];

    int               read_bursts;
    int               write_bursts;
    cache_pkg::addr_t last_araddr;
    cache_pkg::addr_t last_awaddr;

    dcache_top i_dcache_top (
        .clk, .rst, .cpu_req, .cpu_resp, .rd_req, .rd_resp, .wr_req, .wr_resp
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cache_pkg::word_t actual,
                              input cache_pkg::word_t expected);
        if (actual !== expected) begin
            $display("ERR %s: got %h, expected %h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::addr_t actual,
                              input cache_pkg::addr_t expected);
        if (actual !== expected) begin
            $display("ERR %s: got %h, expected %h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERR %s: got %h, expected %h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // Untouched memory returns a pattern of the full address
    function automatic cache_pkg::word_t mem_read(input cache_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {~a[15:0], a[31:16]} ^ 32'h1f2e_3d4c;
    endfunction

    function automatic cache_pkg::word_t expected_word(input cache_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return mem_read(a);
    endfunction

    function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old_word,
                                                     input cache_pkg::word_t new_word,
                                                     input cache_pkg::byte_en_t be);
        cache_pkg::word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // One CPU request, held until the edge where stall is low
    task automatic cpu_access(input logic is_write, input cache_pkg::addr_t a,
                              input cache_pkg::word_t wdata, input cache_pkg::byte_en_t be);
        cache_pkg::word_t exp_word;
        exp_word        = expected_word(a);
        cpu_req.read    = !is_write;
        cpu_req.write   = is_write;
        cpu_req.addr    = a;
        cpu_req.wdata   = wdata;
        cpu_req.byte_en = be;
        @(negedge clk);
        while (cpu_resp.stall) begin
            @(negedge clk);
        end
        next_cycle();
        cpu_req.read  = 1'b0;
        cpu_req.write = 1'b0;
        if (is_write) begin
            shadow[a] = merge_bytes(exp_word, wdata, be);
        end else begin
            check_word("rdata", cpu_resp.rdata, exp_word);
        end
    endtask

    // Memory read channel with random ready delays
    task automatic serve_reads();
        cache_pkg::addr_t a;
        wait (rst == 1'b0);
        forever begin
            while (!rd_req.arvalid) begin
                next_cycle();
            end
            repeat ($urandom_range(3, 0)) next_cycle();
            a = rd_req.araddr;
            // Refill is for the line of the stalled request
            check_addr("araddr", a, {cpu_req.addr[31:4], 4'h0});
            rd_resp.arready = 1'b1;
            next_cycle();
            rd_resp.arready = 1'b0;
            read_bursts++;
            last_araddr = a;
            for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
                repeat ($urandom_range(3, 0)) next_cycle();
                check_flag("rready", rd_req.rready, 1'b1);
                rd_resp.rvalid = 1'b1;
                rd_resp.rdata  = mem_read(a + cache_pkg::addr_t'(cache_pkg::WORD_BYTES * i));
                rd_resp.rlast  = i == cache_pkg::WORDS_PER_LINE - 1;
                next_cycle();
                rd_resp.rvalid = 1'b0;
                rd_resp.rlast  = 1'b0;
            end
        end
    endtask

    // Memory write channel, every beat compared with the shadow line
    task automatic serve_writes();
        cache_pkg::addr_t a;
        cache_pkg::addr_t beat_addr;
        wait (rst == 1'b0);
        forever begin
            while (!wr_req.awvalid) begin
                next_cycle();
            end
            repeat ($urandom_range(3, 0)) next_cycle();
            a = wr_req.awaddr;
            // Victim sits in the set of the stalled request
            check_addr("awaddr", a, {a[31:7], cpu_req.addr[6:4], 4'h0});
            wr_resp.awready = 1'b1;
            next_cycle();
            wr_resp.awready = 1'b0;
            for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
                repeat ($urandom_range(3, 0)) next_cycle();
                beat_addr = a + cache_pkg::addr_t'(cache_pkg::WORD_BYTES * i);
                check_flag("wvalid", wr_req.wvalid, 1'b1);
                check_flag("wlast", wr_req.wlast, i == cache_pkg::WORDS_PER_LINE - 1);
                check_word("wdata", wr_req.wdata, expected_word(beat_addr));
                mem[beat_addr] = wr_req.wdata;
                wr_resp.wready = 1'b1;
                next_cycle();
                wr_resp.wready = 1'b0;
            end
            repeat ($urandom_range(3, 0)) next_cycle();
            check_flag("bready", wr_req.bready, 1'b1);
            wr_resp.bvalid = 1'b1;
            next_cycle();
            wr_resp.bvalid = 1'b0;
            write_bursts++;
            last_awaddr = a;
        end
    endtask

    task automatic run_watchdog();
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        stop_with_failure();
    endtask

    task automatic reset_and_first_read();
        int bursts;
        for (int i = 0; i < cache_pkg::SETS; i++) begin
            check_flag("stall", cpu_resp.stall, 1'b1);
            next_cycle();
        end
        check_flag("stall", cpu_resp.stall, 1'b0);
        bursts = read_bursts;
        cpu_access(1'b0, 32'h0000_0124, '0, '0);
        if (read_bursts != bursts + 1) begin
            $display("First read caused %0d read bursts instead of one", read_bursts - bursts);
            stop_with_failure();
        end
        check_addr("araddr", last_araddr, 32'h0000_0120);
    endtask

    task automatic read_hit_same_line();
        int bursts;
        bursts = read_bursts;
        cpu_access(1'b0, 32'h0000_0128, '0, '0);
        check_flag("arvalid", rd_req.arvalid, 1'b0);
        if (read_bursts != bursts) begin
            $display("Read hit started a read burst");
            stop_with_failure();
        end
    endtask

    task automatic partial_write_readback();
        cache_pkg::word_t old_word;
        old_word = expected_word(32'h0000_012c);
        cpu_access(1'b1, 32'h0000_012c, 32'ha1b2_c3d4, 4'b0101);
        cpu_access(1'b0, 32'h0000_012c, '0, '0);
        check_word("rdata", cpu_resp.rdata, {old_word[31:24], 8'hb2, old_word[15:8], 8'hd4});
    endtask

    // Three lines in set 4, two ways, so one dirty line must go
    task automatic dirty_line_eviction();
        cache_pkg::addr_t bases [3];
        int               writes;
        bases[0] = 32'h0000_1040;
        bases[1] = 32'h0000_2040;
        bases[2] = 32'h0000_3040;
        writes   = write_bursts;
        for (int k = 0; k < 3; k++) begin
            cpu_access(1'b1, bases[k] + cache_pkg::addr_t'(4 * k), 32'hc0de_0000 + k, 4'hf);
        end
        if (write_bursts == writes) begin
            $display("No write-back happened after filling one set with three dirty lines");
            stop_with_failure();
        end
        if (last_awaddr != bases[0] && last_awaddr != bases[1] && last_awaddr != bases[2]) begin
            $display("ERR awaddr: got %h, expected one of %h %h %h",
                     last_awaddr, bases[0], bases[1], bases[2]);
            stop_with_failure();
        end
        for (int k = 0; k < 3; k++) begin
            cpu_access(1'b0, bases[k] + cache_pkg::addr_t'(4 * k), '0, '0);
        end
    endtask

    // Four tags over sets 0 and 1 keep the victim logic busy
    task automatic random_mix();
        cache_pkg::addr_t a;
        logic             is_write;
        int               t;
        int               s;
        int               w;
        for (int n = 0; n < 200; n++) begin
            t        = $urandom_range(3, 0);
            s        = $urandom_range(1, 0);
            w        = $urandom_range(3, 0);
            is_write = $urandom_range(1, 0) == 1;
            a        = 32'h0001_0000 + cache_pkg::addr_t'(t * 128 + s * 16 + w * 4);
            cpu_access(is_write, a, $urandom, cache_pkg::byte_en_t'($urandom_range(15, 0)));
        end
    endtask

    initial begin
        void'($urandom(32'h44aa_4233));
        clk          = 1'b0;
        rst          = 1'b1;
        cpu_req      = '0;
        rd_resp      = '0;
        wr_resp      = '0;
        read_bursts  = 0;
        write_bursts = 0;
        last_araddr  = '0;
        last_awaddr  = '0;
        fork
            serve_reads();
            serve_writes();
            run_watchdog();
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_and_first_read();
        read_hit_same_line();
        partial_write_readback();
        dirty_line_eviction();
        random_mix();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- build.f
hw/cache_pkg.sv
hw/bus_pkg.sv
hw/line_fill.sv
hw/line_evict.sv
hw/dcache_ways.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/dcache_asserts.sv
verification/tb_dcache.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f build.f --top-module tb_dcache -o tb_dcache
	./obj_dir/tb_dcache > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
